// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fb_arbiter_tb
FILELIST  := fb_arbiter.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bank_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_rotator (
	input  logic              clk_133M,
	input  logic              rst_133,
	input  logic              wr_frame_end_i,	// camera finished a frame
	input  logic              rd_frame_end_i,	// display starts a frame
	output fb_pkg::bank_map_t bank_map_o
);

	import fb_pkg::*;

	bank_map_t bank_map;
	bank_map_t bank_map_nxt;
	logic      swap_wr;
	logic      swap_rd;

	assign swap_wr = wr_frame_end_i;
	// display only moves on when a newer full frame sits in spare
	// a write swap in the same cycle defers it to the next vga frame
	assign swap_rd = rd_frame_end_i & bank_map.swap_pending & ~wr_frame_end_i;

	always_comb begin
		bank_map_nxt = bank_map;
		if (swap_wr) begin
			bank_map_nxt.cam_bank     = bank_map.spare_bank;	// write into the free bank
			bank_map_nxt.spare_bank   = bank_map.cam_bank;	// finished frame parks here
			bank_map_nxt.swap_pending = 1'b1;
		end else if (swap_rd) begin
			bank_map_nxt.vga_bank     = bank_map.spare_bank;	// show the newest full frame
			bank_map_nxt.spare_bank   = bank_map.vga_bank;
			bank_map_nxt.swap_pending = 1'b0;
		end
	end

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			bank_map.cam_bank     <= BANK_CAM_INIT;
			bank_map.vga_bank     <= BANK_VGA_INIT;
			bank_map.spare_bank   <= BANK_SPARE_INIT;
			bank_map.swap_pending <= 1'b0;
		end else begin
			bank_map <= bank_map_nxt;
		end
	end

	assign bank_map_o = bank_map;	// new banks show up one cycle after the pulse

endmodule

`default_nettype wire

// ==== cam_line_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_line_counter (
	input  logic clk_133M,
	input  logic rst_133,	// async, active low
	input  logic cam_href_i,	// from camera pclk domain
	input  logic cam_vsyn_i,	// from camera pclk domain
	output logic line_full_o
);

	import fb_pkg::*;

	logic href_s1, href_s2, href_d;	// 2ff sync then edge reg
	logic vsyn_s1, vsyn_s2, vsyn_d;
	logic href_rise;
	logic vsyn_fall;
	logic [LINE_CNT_W-1:0] line_cnt;

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			href_s1 <= 1'b0;
			href_s2 <= 1'b0;
			href_d  <= 1'b0;
			vsyn_s1 <= 1'b0;
			vsyn_s2 <= 1'b0;
			vsyn_d  <= 1'b0;
		end else begin
			href_s1 <= cam_href_i;
			href_s2 <= href_s1;
			href_d  <= href_s2;
			vsyn_s1 <= cam_vsyn_i;
			vsyn_s2 <= vsyn_s1;
			vsyn_d  <= vsyn_s2;
		end
	end

	assign href_rise = href_s2 & ~href_d;	// start of a camera line
	assign vsyn_fall = vsyn_d & ~vsyn_s2;	// frame restarts

	// lines in the current frame, vsync clear wins over a line start
	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			line_cnt <= '0;
		end else if (vsyn_fall) begin
			line_cnt <= '0;
		end else if (href_rise) begin
			line_cnt <= line_cnt + LINE_CNT_W'(1);
		end
	end

	assign line_full_o = (line_cnt == LINES_PER_FRAME);	// held until the next vsync fall

endmodule

`default_nettype wire

// ==== fb_arbiter.f ====
fb_pkg.sv
cam_line_counter.sv
bank_rotator.sv
wr_sequencer.sv
rd_sequencer.sv
fb_arbiter_top.sv
fb_arbiter_props.sv
fb_clk_gen.sv
fb_arbiter_tb.sv

// ==== fb_arbiter_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter_props (
	input logic               clk_133M,
	input logic               rst_133,
	input fb_pkg::sdram_req_t wr_i,
	input fb_pkg::sdram_req_t rd_i,
	input logic               wr_ack_i,
	input logic               rd_ack_i,
	input logic               clear_wr_i,
	input logic               clear_rd_i
);

	int unsigned fail_cnt = 0;	// failed assertions so far

	// open request holds level and address until ack or frame abort
	wr_hold: assert property (@(posedge clk_133M) disable iff (!rst_133)
		wr_i.req && !wr_ack_i && !clear_wr_i |=> wr_i.req && $stable(wr_i.addr))
		else begin
			$error("write request dropped or address moved before its ack");
			fail_cnt++;
		end

	rd_hold: assert property (@(posedge clk_133M) disable iff (!rst_133)
		rd_i.req && !rd_ack_i && !clear_rd_i |=> rd_i.req && $stable(rd_i.addr))
		else begin
			$error("read request dropped or address moved before its ack");
			fail_cnt++;
		end

	// fifo clears are strobes
	clr_wr_pulse: assert property (@(posedge clk_133M) disable iff (!rst_133)
		clear_wr_i |=> !clear_wr_i)
		else begin
			$error("write fifo clear held for more than one cycle");
			fail_cnt++;
		end

	clr_rd_pulse: assert property (@(posedge clk_133M) disable iff (!rst_133)
		clear_rd_i |=> !clear_rd_i)
		else begin
			$error("read fifo clear held for more than one cycle");
			fail_cnt++;
		end

	rst_quiet: assert property (@(posedge clk_133M) !rst_133 |-> !wr_i.req && !rd_i.req)
		else begin
			$error("request high while in reset");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// ==== fb_arbiter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter_tb;

	import fb_pkg::*;

	localparam logic [2:0] K_IDLE  = 3'd0;	// fifo levels idle, nothing may move
	localparam logic [2:0] K_WR    = 3'd1;	// write fifo at 600, count = rows
	localparam logic [2:0] K_RD    = 3'd2;	// read fifo at 100, count = rows
	localparam logic [2:0] K_CAM   = 3'd3;	// count = href lines, then vsync
	localparam logic [2:0] K_VGA   = 3'd4;	// one vga vsync pulse
	localparam int         N_STEPS = 11;

	typedef struct packed {
		logic [2:0]        kind;
		logic [12:0]       count;
		logic [BANK_W-1:0] wr_bank;	// expected once the step is done
		logic [ROW_W-1:0]  wr_row;
		logic [BANK_W-1:0] rd_bank;
		logic [ROW_W-1:0]  rd_row;
	} step_t;

	logic                  clk_133M;
	logic                  rst_133;
	logic                  cam_href, cam_vsyn, vga_vsyn;
	logic                  wr_ack, rd_ack;
	logic [FIFO_CNT_W-1:0] wr_fifo_used, rd_fifo_used;
	sdram_req_t            wr_bus, rd_bus;
	logic                  clear_wr, clear_rd;
	step_t                 steps [N_STEPS];
	int                    err_cnt = 0, check_cnt = 0, step_err = 0;
	int                    cycles = 0, limit = 0;
	int                    wr_clr_cnt = 0, rd_clr_cnt = 0;
	logic [BANK_W-1:0]     m_cam = 2'd1, m_vga = 2'd0, m_spare = 2'd2;	// reference banks
	logic                  m_pend = 1'b0;
	logic [ROW_W-1:0]      m_wr_row = '0, m_rd_row = '0;

	fb_clk_gen u_clk_gen (.clk_133M_o(clk_133M), .rst_133_o(rst_133));

	fb_arbiter_top dut (
		.clk_133M       (clk_133M),
		.rst_133        (rst_133),
		.cam_href_i     (cam_href),
		.cam_vsyn_i     (cam_vsyn),
		.vga_vsyn_i     (vga_vsyn),
		.wr_ack_i       (wr_ack),
		.rd_ack_i       (rd_ack),
		.wr_fifo_used_i (wr_fifo_used),
		.rd_fifo_used_i (rd_fifo_used),
		.wr_o           (wr_bus),
		.rd_o           (rd_bus),
		.clear_wrfifo_o (clear_wr),
		.clear_rdfifo_o (clear_rd)
	);

	bind fb_arbiter_top fb_arbiter_props u_props (
		.clk_133M   (clk_133M),
		.rst_133    (rst_133),
		.wr_i       (wr_o),
		.rd_i       (rd_o),
		.wr_ack_i   (wr_ack_i),
		.rd_ack_i   (rd_ack_i),
		.clear_wr_i (clear_wrfifo_o),
		.clear_rd_i (clear_rdfifo_o)
	);

	always @(negedge clk_133M) begin	// clear strobes seen so far
		if (clear_wr)
			wr_clr_cnt <= wr_clr_cnt + 1;
		if (clear_rd)
			rd_clr_cnt <= rd_clr_cnt + 1;
	end

	always @(posedge clk_133M) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, a request or frame strobe never came", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			step_err++;
			$display("Error: %s expected %h got %h", name, exp, got);
		end
	endtask

	// wait for a request, check it against the model, ack two cycles after the rise
	task automatic serve_row(input logic is_wr, input logic last);
		sdram_req_t        req_s;
		logic [ADDR_W-1:0] exp_addr;
		do begin
			@(negedge clk_133M);
			req_s = is_wr ? wr_bus : rd_bus;
		end while (!req_s.req);
		if (is_wr) begin
			exp_addr = {m_cam, m_wr_row, {COL_W{1'b0}}};
			check_hex("wr_o.addr.flat", 32'(req_s.addr.flat), 32'(exp_addr));
			m_wr_row = m_wr_row + ROW_W'(1);
		end else begin
			exp_addr = {m_vga, m_rd_row, {COL_W{1'b0}}};
			check_hex("rd_o.addr.flat", 32'(req_s.addr.flat), 32'(exp_addr));
			m_rd_row = m_rd_row + ROW_W'(1);
		end
		repeat (2) @(posedge clk_133M);
		if (is_wr)
			wr_ack <= 1'b1;
		else
			rd_ack <= 1'b1;
		if (last) begin	// back to idle levels so no new request opens
			wr_fifo_used <= '0;
			rd_fifo_used <= FIFO_CNT_W'(1800);
		end
		@(posedge clk_133M);
		wr_ack <= 1'b0;
		rd_ack <= 1'b0;
	endtask

	task automatic watch_idle(input int n);
		repeat (n) begin
			@(negedge clk_133M);
			check_hex("wr_o.req", 32'(wr_bus.req), 32'(0));
			check_hex("rd_o.req", 32'(rd_bus.req), 32'(0));
			check_hex("clear_wrfifo_o", 32'(clear_wr), 32'(0));
			check_hex("clear_rdfifo_o", 32'(clear_rd), 32'(0));
		end
	endtask

	task automatic send_cam_frame(input int lines);
		int len;
		int clr0;
		clr0 = wr_clr_cnt;
		for (int i = 0; i < lines; i++) begin
			len = 3 + int'($urandom % 5);	// jittered line length
			@(posedge clk_133M);
			cam_href <= 1'b1;
			repeat (len) @(posedge clk_133M);
			cam_href <= 1'b0;
			repeat (3) @(posedge clk_133M);
		end
		cam_vsyn <= 1'b1;
		repeat (4) @(posedge clk_133M);
		cam_vsyn <= 1'b0;
		while (wr_clr_cnt == clr0)
			@(negedge clk_133M);
		repeat (6) @(negedge clk_133M);	// vsync fall through the syncs
		check_cnt++;
		if (wr_clr_cnt != clr0 + 1) begin
			err_cnt++;
			step_err++;
			$display("clear_wrfifo_o pulsed %0d times in one camera frame", wr_clr_cnt - clr0);
		end
		{m_cam, m_spare} = {m_spare, m_cam};	// camera moves to the free bank
		m_pend   = 1'b1;
		m_wr_row = '0;
	endtask

	task automatic send_vga_vsync();
		int clr0;
		clr0 = rd_clr_cnt;
		@(posedge clk_133M);
		vga_vsyn <= 1'b1;
		repeat (6) @(posedge clk_133M);
		vga_vsyn <= 1'b0;
		while (rd_clr_cnt == clr0)
			@(negedge clk_133M);
		repeat (4) @(negedge clk_133M);
		check_cnt++;
		if (rd_clr_cnt != clr0 + 1) begin
			err_cnt++;
			step_err++;
			$display("clear_rdfifo_o pulsed %0d times for one vsync", rd_clr_cnt - clr0);
		end
		if (m_pend) begin
			{m_vga, m_spare} = {m_spare, m_vga};
			m_pend = 1'b0;
		end
		m_rd_row = '0;
	endtask

	function automatic int step_cycles(input step_t st);
		case (st.kind)
			K_WR, K_RD: return 8 * int'(st.count);
			K_CAM:      return 12 * int'(st.count) + 40;
			K_VGA:      return 40;
			default:    return int'(st.count) + 10;
		endcase
	endfunction

	initial begin
		int    total;
		step_t st;
		void'($urandom(88));
		cam_href     = 1'b0;
		cam_vsyn     = 1'b0;
		vga_vsyn     = 1'b0;
		wr_ack       = 1'b0;
		rd_ack       = 1'b0;
		wr_fifo_used = '0;
		rd_fifo_used = FIFO_CNT_W'(1800);	// read fifo full, no reads
		// kind, count, wr bank, wr row, rd bank, rd row
		steps[0]  = '{K_IDLE, 13'd8,   2'd1, 13'd0,   2'd0, 13'd0};	// out of reset
		steps[1]  = '{K_WR,   13'd4,   2'd1, 13'd4,   2'd0, 13'd0};
		steps[2]  = '{K_RD,   13'd3,   2'd1, 13'd4,   2'd0, 13'd3};
		steps[3]  = '{K_IDLE, 13'd20,  2'd1, 13'd4,   2'd0, 13'd3};	// read fifo at 1800
		steps[4]  = '{K_WR,   13'd746, 2'd1, 13'd750, 2'd0, 13'd3};	// rest of the frame
		steps[5]  = '{K_CAM,  13'd480, 2'd2, 13'd0,   2'd0, 13'd3};
		steps[6]  = '{K_WR,   13'd2,   2'd2, 13'd2,   2'd0, 13'd3};
		steps[7]  = '{K_VGA,  13'd1,   2'd2, 13'd2,   2'd1, 13'd0};	// picks up new frame
		steps[8]  = '{K_RD,   13'd2,   2'd2, 13'd2,   2'd1, 13'd2};
		steps[9]  = '{K_VGA,  13'd1,   2'd2, 13'd2,   2'd1, 13'd0};	// nothing pending
		steps[10] = '{K_RD,   13'd2,   2'd2, 13'd2,   2'd1, 13'd2};
		total = 0;
		foreach (steps[k])
			total += step_cycles(steps[k]) + 4;
		limit = 2 * total + 40;
		wait (rst_133 === 1'b1);
		repeat (2) @(posedge clk_133M);
		for (int i = 0; i < N_STEPS; i++) begin
			st       = steps[i];
			step_err = 0;
			@(posedge clk_133M);
			case (st.kind)
				K_WR: begin
					wr_fifo_used <= FIFO_CNT_W'(600);
					for (int r = 0; r < int'(st.count); r++)
						serve_row(1'b1, r == int'(st.count) - 1);
				end
				K_RD: begin
					rd_fifo_used <= FIFO_CNT_W'(100);
					for (int r = 0; r < int'(st.count); r++)
						serve_row(1'b0, r == int'(st.count) - 1);
				end
				K_CAM:   send_cam_frame(int'(st.count));
				K_VGA:   send_vga_vsync();
				default: watch_idle(int'(st.count));
			endcase
			repeat (2) @(negedge clk_133M);
			check_hex("wr_o.addr.fld.bank", 32'(wr_bus.addr.fld.bank), 32'(st.wr_bank));
			check_hex("wr_o.addr.fld.row", 32'(wr_bus.addr.fld.row), 32'(st.wr_row));
			check_hex("rd_o.addr.fld.bank", 32'(rd_bus.addr.fld.bank), 32'(st.rd_bank));
			check_hex("rd_o.addr.fld.row", 32'(rd_bus.addr.fld.row), 32'(st.rd_row));
			$display("step %0d kind %0d count %0d: %s", i, st.kind, st.count,
				(step_err == 0) ? "ok" : "FAILED");
		end
		err_cnt += int'(dut.u_props.fail_cnt);	// assertion failures count too
		$display("%0d steps, %0d checks, %0d errors", N_STEPS, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== fb_arbiter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter_top (
	input  logic                          clk_133M,
	input  logic                          rst_133,	// async, active low
	input  logic                          cam_href_i,	// async
	input  logic                          cam_vsyn_i,	// async
	input  logic                          vga_vsyn_i,	// async
	input  logic                          wr_ack_i,
	input  logic                          rd_ack_i,
	input  logic [fb_pkg::FIFO_CNT_W-1:0] wr_fifo_used_i,
	input  logic [fb_pkg::FIFO_CNT_W-1:0] rd_fifo_used_i,
	output fb_pkg::sdram_req_t            wr_o,
	output fb_pkg::sdram_req_t            rd_o,
	output logic                          clear_wrfifo_o,
	output logic                          clear_rdfifo_o
);

	import fb_pkg::*;

	logic      line_full;
	logic      wr_frame_end;
	logic      rd_frame_end;
	bank_map_t bank_map;

	cam_line_counter u_cam_line_counter (
		.clk_133M    (clk_133M),
		.rst_133     (rst_133),
		.cam_href_i  (cam_href_i),
		.cam_vsyn_i  (cam_vsyn_i),
		.line_full_o (line_full)
	);

	bank_rotator u_bank_rotator (
		.clk_133M       (clk_133M),
		.rst_133        (rst_133),
		.wr_frame_end_i (wr_frame_end),
		.rd_frame_end_i (rd_frame_end),
		.bank_map_o     (bank_map)
	);

	wr_sequencer u_wr_sequencer (
		.clk_133M       (clk_133M),
		.rst_133        (rst_133),
		.line_full_i    (line_full),
		.wr_ack_i       (wr_ack_i),
		.wr_fifo_used_i (wr_fifo_used_i),
		.cam_bank_i     (bank_map.cam_bank),	// camera side bank
		.wr_o           (wr_o),
		.wr_frame_end_o (wr_frame_end)
	);

	rd_sequencer u_rd_sequencer (
		.clk_133M       (clk_133M),
		.rst_133        (rst_133),
		.vga_vsyn_i     (vga_vsyn_i),
		.rd_ack_i       (rd_ack_i),
		.rd_fifo_used_i (rd_fifo_used_i),
		.vga_bank_i     (bank_map.vga_bank),	// display side bank
		.rd_o           (rd_o),
		.rd_frame_end_o (rd_frame_end)
	);

	// frame boundaries flush the fifos
	assign clear_wrfifo_o = wr_frame_end;
	assign clear_rdfifo_o = rd_frame_end;

endmodule

`default_nettype wire

// ==== fb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_clk_gen (
	output logic clk_133M_o,
	output logic rst_133_o	// active low
);

	initial begin
		clk_133M_o = 1'b0;
		forever #20 clk_133M_o = ~clk_133M_o;	// 40 ns period
	end

	initial begin
		rst_133_o = 1'b0;
		repeat (5) @(posedge clk_133M_o);
		rst_133_o <= 1'b1;	// released on the 5th edge
	end

endmodule

`default_nettype wire

// ==== fb_pkg.sv ====
`default_nettype none

package fb_pkg;

	// sdram word address: bank | row | column
	localparam int unsigned BANK_W = 2;
	localparam int unsigned ROW_W  = 13;
	localparam int unsigned COL_W  = 9;	// always 0, one request moves a full row burst
	localparam int unsigned ADDR_W = BANK_W + ROW_W + COL_W;	// 24

	localparam int unsigned FIFO_CNT_W = 11;	// fill level of both fifos
	localparam int unsigned LINE_CNT_W = 10;	// camera line counter, some headroom past 480

	// frame geometry and fifo watermarks
	localparam logic [ROW_W-1:0]      FRAME_ROWS      = ROW_W'(750);
	localparam logic [LINE_CNT_W-1:0] LINES_PER_FRAME = LINE_CNT_W'(480);
	localparam logic [FIFO_CNT_W-1:0] WR_FIFO_THRESH  = FIFO_CNT_W'(512);	// a burst is waiting
	localparam logic [FIFO_CNT_W-1:0] RD_FIFO_LIMIT   = FIFO_CNT_W'(1500);	// room for a row

	// bank assignment out of reset
	localparam logic [BANK_W-1:0] BANK_VGA_INIT   = BANK_W'(0);
	localparam logic [BANK_W-1:0] BANK_CAM_INIT   = BANK_W'(1);
	localparam logic [BANK_W-1:0] BANK_SPARE_INIT = BANK_W'(2);

	typedef struct packed {
		logic [BANK_W-1:0] bank;	// msbs
		logic [ROW_W-1:0]  row;
		logic [COL_W-1:0]  col;	// lsbs
	} fb_addr_fld_t;

	// same 24 bit word, seen flat by the controller or split into fields
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		fb_addr_fld_t      fld;
	} fb_addr_u;

	typedef struct packed {
		logic     req;	// level, held until ack
		fb_addr_u addr;
	} sdram_req_t;

	typedef struct packed {
		logic [BANK_W-1:0] cam_bank;	// being written by the camera
		logic [BANK_W-1:0] vga_bank;	// being shown
		logic [BANK_W-1:0] spare_bank;	// last complete frame or free
		logic              swap_pending;	// spare holds a newer frame than vga
	} bank_map_t;

endpackage

`default_nettype wire

// ==== rd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_sequencer (
	input  logic                          clk_133M,
	input  logic                          rst_133,
	input  logic                          vga_vsyn_i,	// from vga pixel clock domain
	input  logic                          rd_ack_i,	// one cycle pulse from controller
	input  logic [fb_pkg::FIFO_CNT_W-1:0] rd_fifo_used_i,
	input  logic [fb_pkg::BANK_W-1:0]     vga_bank_i,
	output fb_pkg::sdram_req_t            rd_o,
	output logic                          rd_frame_end_o
);

	import fb_pkg::*;

	logic             vsyn_s1, vsyn_s2;	// 2ff sync
	logic             vsyn_d;	// edge reg
	logic             frame_start;
	logic             fifo_room;
	logic             rd_req;
	logic [ROW_W-1:0] rd_row;	// next row to fetch
	fb_addr_u         rd_addr;

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			vsyn_s1 <= 1'b0;
			vsyn_s2 <= 1'b0;
			vsyn_d  <= 1'b0;
		end else begin
			vsyn_s1 <= vga_vsyn_i;
			vsyn_s2 <= vsyn_s1;
			vsyn_d  <= vsyn_s2;
		end
	end

	assign frame_start = vsyn_s2 & ~vsyn_d;	// vsync rise
	assign fifo_room   = (rd_fifo_used_i <= RD_FIFO_LIMIT);	// space for one more row

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			rd_req <= 1'b0;
			rd_row <= '0;
		end else if (frame_start) begin
			rd_req <= 1'b0;	// drop whatever was open
			rd_row <= '0;
		end else if (!rd_req) begin
			if (fifo_room)
				rd_req <= 1'b1;
		end else if (rd_ack_i) begin
			rd_req <= 1'b0;
			rd_row <= rd_row + ROW_W'(1);
		end
	end

	always_comb begin
		rd_addr.fld.bank = vga_bank_i;	// follows the displayed bank
		rd_addr.fld.row  = rd_row;
		rd_addr.fld.col  = '0;
	end

	assign rd_o           = '{req: rd_req, addr: rd_addr};
	assign rd_frame_end_o = frame_start;	// also flushes the read fifo

endmodule

`default_nettype wire

// ==== wr_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_sequencer (
	input  logic                          clk_133M,
	input  logic                          rst_133,
	input  logic                          line_full_i,	// camera sent all lines
	input  logic                          wr_ack_i,	// one cycle pulse from controller
	input  logic [fb_pkg::FIFO_CNT_W-1:0] wr_fifo_used_i,
	input  logic [fb_pkg::BANK_W-1:0]     cam_bank_i,
	output fb_pkg::sdram_req_t            wr_o,
	output logic                          wr_frame_end_o
);

	import fb_pkg::*;

	logic             wr_req;
	logic [ROW_W-1:0] wr_row;	// next row to write
	logic             fifo_ready;
	logic             frame_end;
	fb_addr_u         wr_addr;

	assign fifo_ready = (wr_fifo_used_i >= WR_FIFO_THRESH);	// a full burst waits
	assign frame_end  = line_full_i & (wr_row >= FRAME_ROWS);

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			wr_req <= 1'b0;
			wr_row <= '0;
		end else if (frame_end) begin
			// frame done, abort any open request
			wr_req <= 1'b0;
			wr_row <= '0;
		end else if (!wr_req) begin
			if (fifo_ready)
				wr_req <= 1'b1;
		end else if (wr_ack_i) begin
			wr_req <= 1'b0;	// low at least one cycle
			wr_row <= wr_row + ROW_W'(1);
		end
	end

	// bank comes live from the rotator
	always_comb begin
		wr_addr.fld.bank = cam_bank_i;
		wr_addr.fld.row  = wr_row;
		wr_addr.fld.col  = '0;	// whole row burst
	end

	assign wr_o = '{req: wr_req, addr: wr_addr};

	// single cycle, row is zero right after
	assign wr_frame_end_o = frame_end;

endmodule

`default_nettype wire
